/* acc_dispatcher.f */
+incdir+design
design/acc_dispatch_pkg.sv
design/acc_head_if.sv
design/acc_insn_queue.sv
design/acc_spec_tracker.sv
design/acc_req_register.sv
design/acc_mem_tracker.sv
design/acc_dispatcher.sv
tests/tb_clock_gen.sv
tests/acc_dispatcher_tb.sv

/* design/acc_dispatch_consts.svh */
`ifndef ACC_DISPATCH_CONSTS_SVH
`define ACC_DISPATCH_CONSTS_SVH

// Entries in the instruction queue
`define ACC_QUEUE_DEPTH 3

// Scoreboard transaction ID width
`define ACC_TRANS_ID_BITS 3

// Scoreboard size, one bitmap bit per entry
`define ACC_NR_SB_ENTRIES 8

// Operand width toward the accelerator
`define ACC_XLEN 32

// Width of each load/store counter
`define ACC_CNT_WIDTH 3

`endif

/* design/acc_dispatch_pkg.sv */
package acc_dispatch_pkg;

  `include "acc_dispatch_consts.svh"

  // Functional unit selected by the issue stage
  typedef enum logic [1:0] {
    NONE,
    LOAD,
    STORE,
    ACCEL
  } fu_e;

  // Memory class of an accelerator instruction
  typedef enum logic [1:0] {
    ACC_OP_OTHER,
    ACC_OP_LOAD,
    ACC_OP_STORE
  } acc_op_e;

  // Floating-point rounding mode from fcsr
  typedef logic [2:0] roundmode_t;

  // One queued accelerator instruction
  typedef struct packed {
    logic [31:0]                   insn;
    logic [`ACC_XLEN-1:0]          rs1;
    logic [`ACC_XLEN-1:0]          rs2;
    logic [`ACC_TRANS_ID_BITS-1:0] trans_id;
    acc_op_e                       op;
  } acc_insn_t;

endpackage

/* design/acc_dispatcher.sv */
`timescale 1ns/10ps

`include "acc_dispatch_consts.svh"

module acc_dispatcher (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          cons_en_i,
  input  logic                          issue_valid_i,
  input  acc_dispatch_pkg::fu_e         issue_fu_i,
  input  acc_dispatch_pkg::acc_op_e     issue_op_i,
  input  logic [`ACC_TRANS_ID_BITS-1:0] issue_trans_id_i,
  input  logic [31:0]                   issue_insn_i,
  input  logic [`ACC_XLEN-1:0]          issue_rs1_i,
  input  logic [`ACC_XLEN-1:0]          issue_rs2_i,
  input  acc_dispatch_pkg::roundmode_t  frm_i,
  input  logic                          flush_i,
  input  logic                          commit_valid_i,
  input  logic [`ACC_TRANS_ID_BITS-1:0] commit_trans_id_i,
  input  logic                          st_barrier_i,
  input  logic                          req_ready_i,
  input  logic                          resp_load_complete_i,
  input  logic                          resp_store_complete_i,
  input  logic                          resp_store_pending_i,
  output logic                          issue_stall_o,
  output logic                          req_valid_o,
  output logic [31:0]                   req_insn_o,
  output logic [`ACC_XLEN-1:0]          req_rs1_o,
  output logic [`ACC_XLEN-1:0]          req_rs2_o,
  output acc_dispatch_pkg::roundmode_t  req_frm_o,
  output logic [`ACC_TRANS_ID_BITS-1:0] req_trans_id_o,
  output logic                          halt_o
);

  logic                        accept_d;
  logic                        accept_q;
  acc_dispatch_pkg::acc_insn_t accept_insn_q;
  logic                        queue_can_accept;
  logic                        offer_valid;
  logic                        reg_ready;

  acc_head_if head_if ();

  // Handshake with the issue stage
  assign accept_d = issue_valid_i & (issue_fu_i == acc_dispatch_pkg::ACCEL) &
                    ~issue_stall_o & ~flush_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      accept_q <= 1'b0;
    end else begin
      accept_q <= accept_d;
    end
  end

  // Issue fields packed at acceptance and pushed one cycle later
  always_ff @(posedge clk_i) begin
    if (accept_d) begin
      accept_insn_q <= '{insn: issue_insn_i, rs1: issue_rs1_i, rs2: issue_rs2_i,
                         trans_id: issue_trans_id_i, op: issue_op_i};
    end
  end

  acc_insn_queue u_queue (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .push_i       (accept_q),
    .push_data_i  (accept_insn_q),
    .can_accept_o (queue_can_accept),
    .head_if      (head_if.queue)
  );

  // Pending is marked at the issue handshake so a commit in the push cycle already hits
  acc_spec_tracker u_spec (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .flush_i           (flush_i),
    .accept_i          (accept_d),
    .accept_trans_id_i (issue_trans_id_i),
    .commit_valid_i    (commit_valid_i),
    .commit_trans_id_i (commit_trans_id_i),
    .req_ready_i       (reg_ready),
    .req_valid_o       (offer_valid),
    .head_if           (head_if.tracker)
  );

  acc_req_register u_req (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .valid_i        (offer_valid),
    .data_i         (head_if.head),
    .frm_i          (frm_i),
    .ready_o        (reg_ready),
    .req_valid_o    (req_valid_o),
    .req_insn_o     (req_insn_o),
    .req_rs1_o      (req_rs1_o),
    .req_rs2_o      (req_rs2_o),
    .req_frm_o      (req_frm_o),
    .req_trans_id_o (req_trans_id_o),
    .req_ready_i    (req_ready_i)
  );

  // Speculative counts start at the issue handshake
  acc_mem_tracker u_mem (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .flush_i            (flush_i),
    .cons_en_i          (cons_en_i),
    .accept_i           (accept_d),
    .accept_op_i        (issue_op_i),
    .issue_fu_i         (issue_fu_i),
    .queue_can_accept_i (queue_can_accept),
    .load_complete_i    (resp_load_complete_i),
    .store_complete_i   (resp_store_complete_i),
    .store_pending_i    (resp_store_pending_i),
    .st_barrier_i       (st_barrier_i),
    .issue_stall_o      (issue_stall_o),
    .halt_o             (halt_o),
    .head_if            (head_if.monitor)
  );

endmodule

/* design/acc_head_if.sv */
`timescale 1ns/10ps

interface acc_head_if;

  // Oldest queued instruction, valid while the queue holds one or one falls through
  acc_dispatch_pkg::acc_insn_t head;
  logic                        head_valid;
  // Retires the head at the next edge
  logic                        pop;

  // Queue side
  modport queue (output head, output head_valid, input pop);

  // Speculation tracker decides when the head leaves
  modport tracker (input head, input head_valid, output pop);

  // Memory tracker only watches departures
  modport monitor (input head, input head_valid, input pop);

endinterface

/* design/acc_insn_queue.sv */
`timescale 1ns/10ps

`include "acc_dispatch_consts.svh"

module acc_insn_queue (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        flush_i,
  input  logic                        push_i,
  input  acc_dispatch_pkg::acc_insn_t push_data_i,
  output logic                        can_accept_o,
  acc_head_if.queue                   head_if
);

  localparam int ptr_w   = $clog2(`ACC_QUEUE_DEPTH);
  localparam int usage_w = $clog2(`ACC_QUEUE_DEPTH + 1);

  acc_dispatch_pkg::acc_insn_t mem_q [`ACC_QUEUE_DEPTH];
  logic [ptr_w-1:0]            rd_ptr_q;
  logic [ptr_w-1:0]            wr_ptr_q;
  logic [usage_w-1:0]          usage_q;
  logic                        empty;
  logic                        bypass;
  logic                        do_write;
  logic                        do_read;

  // Wrap at depth, which need not be a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(`ACC_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty = (usage_q == '0);

  // Fall through when empty
  assign head_if.head       = empty ? push_data_i : mem_q[rd_ptr_q];
  assign head_if.head_valid = ~empty | push_i;

  // Pushed entry popped in the same cycle never touches storage
  assign bypass   = empty & push_i & head_if.pop;
  assign do_write = push_i & ~bypass;
  assign do_read  = head_if.pop & ~bypass;

  // One slot stays free for the instruction sitting in the accept register
  assign can_accept_o = usage_q < usage_w'(`ACC_QUEUE_DEPTH - 1);

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_read) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      usage_q <= usage_q + usage_w'(do_write) - usage_w'(do_read);
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_write) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

/* design/acc_mem_tracker.sv */
`timescale 1ns/10ps

`include "acc_dispatch_consts.svh"

module acc_mem_tracker (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      flush_i,
  input  logic                      cons_en_i,
  input  logic                      accept_i,
  input  acc_dispatch_pkg::acc_op_e accept_op_i,
  input  acc_dispatch_pkg::fu_e     issue_fu_i,
  input  logic                      queue_can_accept_i,
  input  logic                      load_complete_i,
  input  logic                      store_complete_i,
  input  logic                      store_pending_i,
  input  logic                      st_barrier_i,
  output logic                      issue_stall_o,
  output logic                      halt_o,
  acc_head_if.monitor               head_if
);

  localparam int cnt_w = `ACC_CNT_WIDTH;

  logic [cnt_w-1:0] spec_ld_q;
  logic [cnt_w-1:0] spec_st_q;
  logic [cnt_w-1:0] disp_ld_q;
  logic [cnt_w-1:0] disp_st_q;
  logic             acc_ld;
  logic             acc_st;
  logic             ld_disp;
  logic             st_disp;
  logic             ld_inflight;
  logic             st_inflight;
  logic             halt_q;

  // Shared up/down step for all four counters
  function automatic logic [cnt_w-1:0] step(input logic [cnt_w-1:0] cnt,
                                            input logic up,
                                            input logic down);
    return cnt + cnt_w'(up) - cnt_w'(down);
  endfunction

  // Newly accepted loads and stores
  assign acc_ld = accept_i & (accept_op_i == acc_dispatch_pkg::ACC_OP_LOAD);
  assign acc_st = accept_i & (accept_op_i == acc_dispatch_pkg::ACC_OP_STORE);

  // Counted at departure from the queue, so back-pressure cannot double count
  assign ld_disp = head_if.pop & head_if.head_valid &
                   (head_if.head.op == acc_dispatch_pkg::ACC_OP_LOAD);
  assign st_disp = head_if.pop & head_if.head_valid &
                   (head_if.head.op == acc_dispatch_pkg::ACC_OP_STORE);

  assign ld_inflight = (spec_ld_q != '0) | (disp_ld_q != '0);
  assign st_inflight = (spec_st_q != '0) | (disp_st_q != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      spec_ld_q <= '0;
      spec_st_q <= '0;
      disp_ld_q <= '0;
      disp_st_q <= '0;
    end else begin
      // Speculative ones vanish on flush
      if (flush_i) begin
        spec_ld_q <= '0;
        spec_st_q <= '0;
      end else begin
        spec_ld_q <= step(spec_ld_q, acc_ld, ld_disp);
        spec_st_q <= step(spec_st_q, acc_st, st_disp);
      end
      // Dispatched ones live until the accelerator completes them
      disp_ld_q <= step(disp_ld_q, ld_disp, load_complete_i);
      disp_st_q <= step(disp_st_q, st_disp, store_complete_i);
    end
  end

  // Issue stall per functional unit
  always_comb begin
    case (issue_fu_i)
      acc_dispatch_pkg::ACCEL: issue_stall_o = ~queue_can_accept_i;
      // Scalar load must not pass an accelerator store
      acc_dispatch_pkg::LOAD:  issue_stall_o = cons_en_i & st_inflight;
      // Scalar store must not pass any accelerator access
      acc_dispatch_pkg::STORE: issue_stall_o = cons_en_i & (ld_inflight | st_inflight);
      default:                 issue_stall_o = 1'b0;
    endcase
  end

  // Store barrier halts the core until the accelerator has no store left
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      halt_q <= 1'b0;
    end else begin
      halt_q <= (halt_q | st_barrier_i) & store_pending_i;
    end
  end

  assign halt_o = halt_q;

endmodule

/* design/acc_req_register.sv */
`timescale 1ns/10ps

`include "acc_dispatch_consts.svh"

module acc_req_register (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          valid_i,
  input  acc_dispatch_pkg::acc_insn_t   data_i,
  input  acc_dispatch_pkg::roundmode_t  frm_i,
  output logic                          ready_o,
  output logic                          req_valid_o,
  output logic [31:0]                   req_insn_o,
  output logic [`ACC_XLEN-1:0]          req_rs1_o,
  output logic [`ACC_XLEN-1:0]          req_rs2_o,
  output acc_dispatch_pkg::roundmode_t  req_frm_o,
  output logic [`ACC_TRANS_ID_BITS-1:0] req_trans_id_o,
  input  logic                          req_ready_i
);

  logic                         full_q;
  acc_dispatch_pkg::acc_insn_t  data_q;
  acc_dispatch_pkg::roundmode_t frm_q;
  acc_dispatch_pkg::acc_insn_t  out_data;

  // Room when empty, or when the held request leaves this cycle
  assign ready_o = ~full_q | req_ready_i;

  // Empty register is transparent
  assign req_valid_o = full_q | valid_i;
  assign out_data    = full_q ? data_q : data_i;
  assign req_frm_o   = full_q ? frm_q : frm_i;

  assign req_insn_o     = out_data.insn;
  assign req_rs1_o      = out_data.rs1;
  assign req_rs2_o      = out_data.rs2;
  assign req_trans_id_o = out_data.trans_id;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      // Draining, refill from whatever is offered now
      if (req_ready_i) begin
        full_q <= valid_i;
      end
    end else begin
      // Pass-through not taken, keep it
      full_q <= valid_i & ~req_ready_i;
    end
  end

  // Rounding mode is captured with the first offer and then held
  always_ff @(posedge clk_i) begin
    if (ready_o) begin
      data_q <= data_i;
      frm_q  <= frm_i;
    end
  end

endmodule

/* design/acc_spec_tracker.sv */
`timescale 1ns/10ps

`include "acc_dispatch_consts.svh"

module acc_spec_tracker (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          flush_i,
  input  logic                          accept_i,
  input  logic [`ACC_TRANS_ID_BITS-1:0] accept_trans_id_i,
  input  logic                          commit_valid_i,
  input  logic [`ACC_TRANS_ID_BITS-1:0] commit_trans_id_i,
  input  logic                          req_ready_i,
  output logic                          req_valid_o,
  acc_head_if.tracker                   head_if
);

  // Pending: received but still speculative
  logic [`ACC_NR_SB_ENTRIES-1:0] pending_d;
  logic [`ACC_NR_SB_ENTRIES-1:0] pending_q;
  // Ready: reached the scoreboard head, waiting to leave the queue
  logic [`ACC_NR_SB_ENTRIES-1:0] ready_d;
  logic [`ACC_NR_SB_ENTRIES-1:0] ready_q;
  logic [`ACC_TRANS_ID_BITS-1:0] head_id;
  logic                          commit_hit;
  logic                          commit_head;

  assign head_id = head_if.head.trans_id;

  // A commit only counts for an instruction we actually hold
  assign commit_hit  = commit_valid_i & pending_q[commit_trans_id_i];
  assign commit_head = commit_hit & (commit_trans_id_i == head_id);

  // Offer the head once non-speculative, or in the very cycle it commits
  assign req_valid_o = head_if.head_valid & (ready_q[head_id] | commit_head);
  assign head_if.pop = req_valid_o & req_ready_i;

  always_comb begin
    pending_d = pending_q;
    ready_d   = ready_q;

    // New instruction enters the queue
    if (accept_i) begin
      pending_d[accept_trans_id_i] = 1'b1;
    end
    // Speculative instructions are dropped
    if (flush_i) begin
      pending_d = '0;
    end

    // Moves from pending to ready
    if (commit_hit) begin
      pending_d[commit_trans_id_i] = 1'b0;
      ready_d[commit_trans_id_i]   = 1'b1;
    end

    // Head left toward the accelerator, clear last so it wins over a same-cycle commit
    if (head_if.pop) begin
      ready_d[head_id] = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
      ready_q   <= '0;
    end else begin
      pending_q <= pending_d;
      ready_q   <= ready_d;
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the acc_dispatcher testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module acc_dispatcher_tb \
  -f acc_dispatcher.f \
  -o acc_dispatcher_sim

./obj_dir/acc_dispatcher_sim 2>&1 | tee sim.log

if grep -qF "*** FAILED ***" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"

/* tests/acc_dispatcher_tb.sv */
`timescale 1ns/10ps

`include "acc_dispatch_consts.svh"

module acc_dispatcher_tb;

  localparam int period_ns = 4;

  // Short codes for the table columns
  localparam int fu_no = acc_dispatch_pkg::NONE;
  localparam int fu_ld = acc_dispatch_pkg::LOAD;
  localparam int fu_st = acc_dispatch_pkg::STORE;
  localparam int fu_ac = acc_dispatch_pkg::ACCEL;
  localparam int op_ot = acc_dispatch_pkg::ACC_OP_OTHER;
  localparam int op_st = acc_dispatch_pkg::ACC_OP_STORE;

  // One row holds inputs for a falling edge and expected outputs before the next rising edge
  typedef struct packed {
    logic                          iv;
    logic [1:0]                    fu;
    logic [1:0]                    op;
    logic [`ACC_TRANS_ID_BITS-1:0] id;
    logic                          cv;
    logic [`ACC_TRANS_ID_BITS-1:0] cid;
    logic                          fl;
    logic                          rdy;
    logic                          cons;
    logic                          bar;
    logic                          stc;
    logic                          stp;
    logic [2:0]                    frm;
    logic                          es;
    logic                          eh;
    logic                          ev;
    logic [`ACC_TRANS_ID_BITS-1:0] eid;
    logic [2:0]                    efrm;
  } step_t;

  logic                          clk_i;
  logic                          rst_i;
  logic                          cons_en_i;
  logic                          issue_valid_i;
  acc_dispatch_pkg::fu_e         issue_fu_i;
  acc_dispatch_pkg::acc_op_e     issue_op_i;
  logic [`ACC_TRANS_ID_BITS-1:0] issue_trans_id_i;
  logic [31:0]                   issue_insn_i;
  logic [`ACC_XLEN-1:0]          issue_rs1_i;
  logic [`ACC_XLEN-1:0]          issue_rs2_i;
  acc_dispatch_pkg::roundmode_t  frm_i;
  logic                          flush_i;
  logic                          commit_valid_i;
  logic [`ACC_TRANS_ID_BITS-1:0] commit_trans_id_i;
  logic                          st_barrier_i;
  logic                          req_ready_i;
  logic                          resp_load_complete_i;
  logic                          resp_store_complete_i;
  logic                          resp_store_pending_i;
  logic                          issue_stall_o;
  logic                          req_valid_o;
  logic [31:0]                   req_insn_o;
  logic [`ACC_XLEN-1:0]          req_rs1_o;
  logic [`ACC_XLEN-1:0]          req_rs2_o;
  acc_dispatch_pkg::roundmode_t  req_frm_o;
  logic [`ACC_TRANS_ID_BITS-1:0] req_trans_id_o;
  logic                          halt_o;

  // Random payload per transaction ID
  logic [31:0]          insn_by_id [`ACC_NR_SB_ENTRIES];
  logic [`ACC_XLEN-1:0] rs1_by_id  [`ACC_NR_SB_ENTRIES];
  logic [`ACC_XLEN-1:0] rs2_by_id  [`ACC_NR_SB_ENTRIES];

  step_t steps [$];
  string names [$];
  logic  steps_built = 1'b0;
  int    checks      = 0;
  int    mismatches  = 0;

  tb_clock_gen #(.period_ns(period_ns), .rst_cycles(2)) u_clk (
    .clk_o (clk_i),
    .rst_o (rst_i)
  );

  acc_dispatcher u_dut (.*);

  task automatic add_step(input string name,
                          input int iv, input int fu, input int op, input int id,
                          input int cv, input int cid, input int fl, input int rdy,
                          input int cons, input int bar, input int stc, input int stp,
                          input int frm, input int es, input int eh, input int ev,
                          input int eid, input int efrm);
    step_t s;
    s = {iv[0], fu[1:0], op[1:0], id[2:0], cv[0], cid[2:0], fl[0], rdy[0], cons[0],
         bar[0], stc[0], stp[0], frm[2:0], es[0], eh[0], ev[0], eid[2:0], efrm[2:0]};
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic drive_step(input step_t s);
    issue_valid_i         = s.iv;
    issue_fu_i            = acc_dispatch_pkg::fu_e'(s.fu);
    issue_op_i            = acc_dispatch_pkg::acc_op_e'(s.op);
    issue_trans_id_i      = s.id;
    issue_insn_i          = insn_by_id[s.id];
    issue_rs1_i           = rs1_by_id[s.id];
    issue_rs2_i           = rs2_by_id[s.id];
    commit_valid_i        = s.cv;
    commit_trans_id_i     = s.cid;
    flush_i               = s.fl;
    req_ready_i           = s.rdy;
    cons_en_i             = s.cons;
    st_barrier_i          = s.bar;
    resp_load_complete_i  = 1'b0;
    resp_store_complete_i = s.stc;
    resp_store_pending_i  = s.stp;
    frm_i                 = s.frm;
  endtask

  task automatic check_value(input string step_name, input string sig,
                             input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      mismatches++;
      $display("Mismatch %s %s: expected %h, actual %h", step_name, sig, exp, act);
    end
  endtask

  // Payload is only meaningful while a request is offered
  task automatic check_step(input string name, input step_t s);
    check_value(name, "issue_stall_o", 32'(s.es), 32'(issue_stall_o));
    check_value(name, "halt_o", 32'(s.eh), 32'(halt_o));
    check_value(name, "req_valid_o", 32'(s.ev), 32'(req_valid_o));
    if (s.ev) begin
      check_value(name, "req_trans_id_o", 32'(s.eid), 32'(req_trans_id_o));
      check_value(name, "req_insn_o", insn_by_id[s.eid], req_insn_o);
      check_value(name, "req_rs1_o", rs1_by_id[s.eid], req_rs1_o);
      check_value(name, "req_rs2_o", rs2_by_id[s.eid], req_rs2_o);
      check_value(name, "req_frm_o", 32'(s.efrm), 32'(req_frm_o));
    end
  endtask

  task automatic build_table();
    //        name           iv fu     op    id cv cid fl rdy cons bar stc stp frm es eh ev eid efrm
    add_step("rst_idle",     0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    // Held until the commit names it
    add_step("spec_issue0",  1, fu_ac, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("spec_wait_a",  0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("spec_wait_b",  0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("spec_wait_c",  0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("spec_commit0", 0, fu_no, op_ot, 0, 1, 0, 0, 1, 0, 0, 0, 0, 6, 0, 0, 1, 0, 6);
    add_step("spec_gone0",   0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 6, 0, 0, 0, 0, 0);
    // Commit right after issue catches the entry as it falls through
    add_step("spec_issue5",  1, fu_ac, op_ot, 5, 0, 0, 0, 1, 0, 0, 0, 0, 6, 0, 0, 0, 0, 0);
    add_step("spec_commit5", 0, fu_no, op_ot, 0, 1, 5, 0, 1, 0, 0, 0, 0, 2, 0, 0, 1, 5, 2);
    // In-order departure with the rounding mode from the cycle of offer
    add_step("ord_issue1",   1, fu_ac, op_ot, 1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("ord_issue2",   1, fu_ac, op_ot, 2, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("ord_issue3",   1, fu_ac, op_ot, 3, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("ord_commit1",  0, fu_no, op_ot, 0, 1, 1, 0, 1, 0, 0, 0, 0, 1, 0, 0, 1, 1, 1);
    add_step("ord_commit2",  0, fu_no, op_ot, 0, 1, 2, 0, 1, 0, 0, 0, 0, 3, 0, 0, 1, 2, 3);
    add_step("ord_commit3",  0, fu_no, op_ot, 0, 1, 3, 0, 1, 0, 0, 0, 0, 4, 0, 0, 1, 3, 4);
    add_step("ord_empty",    0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    // Accelerator not ready so the queue fills and ACCEL issue stalls
    add_step("bp_issue4",    1, fu_ac, op_ot, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("bp_issue5",    1, fu_ac, op_ot, 5, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("bp_issue6",    1, fu_ac, op_ot, 6, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("bp_stall7",    1, fu_ac, op_ot, 7, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0);
    add_step("bp_commit4",   1, fu_ac, op_ot, 7, 1, 4, 0, 0, 0, 0, 0, 0, 2, 1, 0, 1, 4, 2);
    add_step("bp_hold4",     1, fu_ac, op_ot, 7, 1, 5, 0, 0, 0, 0, 0, 0, 5, 1, 0, 1, 4, 2);
    add_step("bp_drain4",    0, fu_no, op_ot, 0, 1, 6, 0, 1, 0, 0, 0, 0, 5, 0, 0, 1, 4, 2);
    add_step("bp_drain5",    0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 6, 0, 0, 1, 5, 5);
    add_step("bp_drain6",    0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 1, 0, 0, 1, 6, 6);
    add_step("bp_empty",     0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    // Flushed IDs stay dead even when committed later
    add_step("fl_issue0",    1, fu_ac, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("fl_issue1",    1, fu_ac, op_ot, 1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("fl_flush",     0, fu_no, op_ot, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("fl_commit0",   0, fu_no, op_ot, 0, 1, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("fl_commit1",   0, fu_no, op_ot, 0, 1, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("fl_quiet",     0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    // In consistent mode a scalar load waits for the accelerator store
    add_step("cs_issue_st2", 1, fu_ac, op_st, 2, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("cs_ld_spec",   1, fu_ld, op_ot, 0, 0, 0, 0, 1, 1, 0, 0, 0, 0, 1, 0, 0, 0, 0);
    add_step("cs_commit2",   1, fu_ld, op_ot, 0, 1, 2, 0, 1, 1, 0, 0, 0, 3, 1, 0, 1, 2, 3);
    add_step("cs_ld_disp",   1, fu_ld, op_ot, 0, 0, 0, 0, 1, 1, 0, 0, 0, 0, 1, 0, 0, 0, 0);
    add_step("cs_st_done",   1, fu_ld, op_ot, 0, 0, 0, 0, 1, 1, 0, 1, 0, 0, 1, 0, 0, 0, 0);
    add_step("cs_ld_free",   1, fu_ld, op_ot, 0, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("cs_st_free",   1, fu_st, op_ot, 0, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    // Same traffic with consistency off never stalls
    add_step("nc_issue_st3", 1, fu_ac, op_st, 3, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("nc_ld_spec",   1, fu_ld, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("nc_commit3",   1, fu_ld, op_ot, 0, 1, 3, 0, 1, 0, 0, 0, 0, 7, 0, 0, 1, 3, 7);
    add_step("nc_st_disp",   1, fu_st, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("nc_st_done",   0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0);
    // Store barrier halt follows store_pending
    add_step("bar_set",      0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0);
    add_step("bar_hold_a",   0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 1, 0, 0, 1, 0, 0, 0);
    add_step("bar_hold_b",   0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 1, 0, 0, 1, 0, 0, 0);
    add_step("bar_release",  0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
    add_step("bar_clear",    0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("bar_no_pend",  0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step("bar_idle",     0, fu_no, op_ot, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
  endtask

  initial begin
    void'($urandom(32'h220e_f88b));
    for (int i = 0; i < `ACC_NR_SB_ENTRIES; i++) begin
      insn_by_id[i] = $urandom();
      rs1_by_id[i]  = $urandom();
      rs2_by_id[i]  = $urandom();
    end
    // All inputs quiet during reset
    drive_step('0);
    build_table();
    steps_built = 1'b1;
    wait (rst_i == 1'b0);
    @(negedge clk_i);
    foreach (steps[i]) begin
      drive_step(steps[i]);
      // Sampled midway before the rising edge
      #1;
      check_step(names[i], steps[i]);
      @(negedge clk_i);
    end
    $display("Summary: %0d checks, %0d mismatches", checks, mismatches);
    if (mismatches == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog covers the table length plus margin
  initial begin
    wait (steps_built);
    repeat (steps.size() + 20) @(posedge clk_i);
    $display("Timeout: table of %0d steps did not finish in time", steps.size());
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int period_ns  = 4,
  parameter int rst_cycles = 2
) (
  output logic clk_o,
  output logic rst_o
);

  // Free-running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2.0) clk_o = ~clk_o;
  end

  // Reset covers the first rising edges, released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (rst_cycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule
